/* axis_width_pkg.sv */
// stream widths fixed at build time; metadata fields assume the 128-bit pipeline user layout
`default_nettype none

package axis_width_pkg;

  // data path
  localparam int tdata_width = 512;
  localparam int tkeep_width = tdata_width / 8;

  // pipeline metadata word
  localparam int tuser_width = 128;

  // frame size field in bytes
  localparam int size_lsb    = 0;
  localparam int size_width  = 16;

  // one-hot interface fields
  localparam int src_lsb     = 16;
  localparam int dst_lsb     = 24;
  localparam int port_width  = 8;

  // finished-frame counters wrap at this width
  localparam int count_width = 16;

endpackage

`default_nettype wire

/* port_map_pkg.sv */
// codes cover the two host DMA queues only; MAC interface codes are not defined here
`default_nettype none

package port_map_pkg;

  // one-hot interface numbers carried in the source field
  localparam logic [7:0] qdma0_ifnum = 8'h02;
  localparam logic [7:0] qdma1_ifnum = 8'h08;

  // destination-field bits that steer a frame to a host queue
  localparam int qdma0_dst_bit = 1;
  localparam int qdma1_dst_bit = 3;

  // queue destination word presented to the host
  localparam logic [15:0] qdma0_dst_code = 16'h0001;
  localparam logic [15:0] qdma1_dst_code = 16'h0002;

  // host-to-card arbiter states
  typedef enum logic [1:0] {
    grant_idle,
    grant_q0,
    grant_q1
  } grant_t;

  // card-to-host frame tracking
  typedef enum logic {
    frame_idle,
    frame_body
  } frame_state_t;

endpackage

`default_nettype wire

/* h2c_arbiter.sv */
// grants whole frames only; a queue that drops valid mid-frame keeps the grant until its last beat
`default_nettype none
`timescale 1ns/10ps

module h2c_arbiter import port_map_pkg::*; (
  input  logic   axis_aclk,
  input  logic   axis_rst,
  input  logic   h2c_0_valid,
  input  logic   h2c_0_last,
  input  logic   h2c_1_valid,
  input  logic   h2c_1_last,
  output logic   h2c_0_ready,
  output logic   h2c_1_ready,
  output grant_t grant,
  output logic   take
);

  grant_t grant_next;
  logic   served_q1;
  logic   take_0;
  logic   take_1;

  // ready follows the grant state, never the valids
  assign h2c_0_ready = (grant == grant_q0);
  assign h2c_1_ready = (grant == grant_q1);

  assign take_0 = h2c_0_valid && h2c_0_ready;
  assign take_1 = h2c_1_valid && h2c_1_ready;
  assign take   = take_0 || take_1;

  always_comb begin
    grant_next = grant;
    case (grant)
      grant_idle: begin
        // both waiting: the queue not served last wins
        if (h2c_0_valid && (!h2c_1_valid || served_q1)) begin
          grant_next = grant_q0;
        end
        else if (h2c_1_valid) begin
          grant_next = grant_q1;
        end
      end
      grant_q0: begin
        if (take_0 && h2c_0_last) begin
          grant_next = h2c_1_valid ? grant_q1 : grant_idle;
        end
      end
      grant_q1: begin
        if (take_1 && h2c_1_last) begin
          grant_next = h2c_0_valid ? grant_q0 : grant_idle;
        end
      end
      default: grant_next = grant_idle;
    endcase
  end

  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      grant     <= grant_idle;
      // start as if queue 1 went last so queue 0 goes first
      served_q1 <= 1'b1;
    end
    else begin
      grant <= grant_next;
      if (take_0 && h2c_0_last) begin
        served_q1 <= 1'b0;
      end
      else if (take_1 && h2c_1_last) begin
        served_q1 <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* h2c_merge.sv */
// output stream has no ready; the pipeline must accept one beat per cycle
`default_nettype none
`timescale 1ns/10ps

module h2c_merge import axis_width_pkg::*, port_map_pkg::*; (
  input  logic                   axis_aclk,
  input  logic                   axis_rst,
  input  grant_t                 grant,
  input  logic                   take,
  input  logic [tdata_width-1:0] h2c_0_data,
  input  logic [tdata_width-1:0] h2c_1_data,
  input  logic [tkeep_width-1:0] h2c_0_keep,
  input  logic [tkeep_width-1:0] h2c_1_keep,
  input  logic                   h2c_0_last,
  input  logic                   h2c_1_last,
  input  logic [size_width-1:0]  h2c_0_size,
  input  logic [size_width-1:0]  h2c_1_size,
  output logic                   pipe_in_valid,
  output logic [tdata_width-1:0] pipe_in_data,
  output logic [tkeep_width-1:0] pipe_in_keep,
  output logic                   pipe_in_last,
  output logic [tuser_width-1:0] pipe_in_user,
  output logic                   h2c_done
);

  logic                   sel_q1;
  logic [tuser_width-1:0] user_mux;

  assign sel_q1 = (grant == grant_q1);

  // metadata: size and source code, destination and the rest left zero
  always_comb begin
    user_mux = '0;
    user_mux[size_lsb +: size_width] = sel_q1 ? h2c_1_size : h2c_0_size;
    user_mux[src_lsb +: port_width]  = sel_q1 ? qdma1_ifnum : qdma0_ifnum;
  end

  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      pipe_in_valid <= 1'b0;
    end
    else begin
      pipe_in_valid <= take;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (take) begin
      pipe_in_data <= sel_q1 ? h2c_1_data : h2c_0_data;
      pipe_in_keep <= sel_q1 ? h2c_1_keep : h2c_0_keep;
      pipe_in_last <= sel_q1 ? h2c_1_last : h2c_0_last;
      pipe_in_user <= user_mux;
    end
  end

  assign h2c_done = pipe_in_valid && pipe_in_last;

endmodule

`default_nettype wire

/* c2h_dispatch.sv */
// both host queues must be ready for any beat to move, so one slow queue stalls both
`default_nettype none
`timescale 1ns/10ps

module c2h_dispatch import axis_width_pkg::*, port_map_pkg::*; (
  input  logic                   axis_aclk,
  input  logic                   axis_rst,
  input  logic                   pipe_out_valid,
  input  logic [tdata_width-1:0] pipe_out_data,
  input  logic [tkeep_width-1:0] pipe_out_keep,
  input  logic                   pipe_out_last,
  input  logic [tuser_width-1:0] pipe_out_user,
  output logic                   pipe_out_ready,
  input  logic                   c2h_0_ready,
  input  logic                   c2h_1_ready,
  output logic                   c2h_0_valid,
  output logic [tdata_width-1:0] c2h_0_data,
  output logic [tkeep_width-1:0] c2h_0_keep,
  output logic                   c2h_0_last,
  output logic [15:0]            c2h_0_size,
  output logic [15:0]            c2h_0_src,
  output logic [15:0]            c2h_0_dst,
  output logic                   c2h_1_valid,
  output logic [tdata_width-1:0] c2h_1_data,
  output logic [tkeep_width-1:0] c2h_1_keep,
  output logic                   c2h_1_last,
  output logic [15:0]            c2h_1_size,
  output logic [15:0]            c2h_1_src,
  output logic [15:0]            c2h_1_dst,
  output logic                   c2h_0_done,
  output logic                   c2h_1_done
);

  frame_state_t          state;
  logic [port_width-1:0] dst_field;
  logic [size_width-1:0] size_field;
  logic [1:0]            sel;
  logic                  accept;
  logic                  first;
  logic [15:0]           code     [2];
  logic [size_width-1:0] size_q   [2];
  logic [size_width-1:0] size_out [2];

  assign dst_field  = pipe_out_user[dst_lsb +: port_width];
  assign size_field = pipe_out_user[size_lsb +: size_width];

  // both bits set is a broadcast to the two queues
  assign sel[0] = dst_field[qdma0_dst_bit];
  assign sel[1] = dst_field[qdma1_dst_bit];

  assign code[0] = qdma0_dst_code;
  assign code[1] = qdma1_dst_code;

  assign pipe_out_ready = c2h_0_ready && c2h_1_ready;
  assign accept         = pipe_out_valid && pipe_out_ready;
  assign first          = (state == frame_idle);

  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      state <= frame_idle;
    end
    else if (accept) begin
      state <= pipe_out_last ? frame_idle : frame_body;
    end
  end

  // per-queue size, captured from the first beat only
  always_ff @(posedge axis_aclk) begin
    for (int i = 0; i < 2; i++) begin
      if (accept && first && sel[i]) begin
        size_q[i] <= size_field;
      end
    end
  end

  // first beat shows the live size, body beats the held one
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      size_out[i] = first ? size_field : size_q[i];
    end
  end

  // a queue sees valid only while the other queue can take the beat too
  assign c2h_0_valid = pipe_out_valid && sel[0] && c2h_1_ready;
  assign c2h_0_data  = pipe_out_data;
  assign c2h_0_keep  = pipe_out_keep;
  assign c2h_0_last  = pipe_out_last;
  assign c2h_0_size  = size_out[0];
  assign c2h_0_src   = {{(16 - port_width){1'b0}}, pipe_out_user[src_lsb +: port_width]};
  assign c2h_0_dst   = code[0];

  assign c2h_1_valid = pipe_out_valid && sel[1] && c2h_0_ready;
  assign c2h_1_data  = pipe_out_data;
  assign c2h_1_keep  = pipe_out_keep;
  assign c2h_1_last  = pipe_out_last;
  assign c2h_1_size  = size_out[1];
  assign c2h_1_src   = c2h_0_src;
  assign c2h_1_dst   = code[1];

  assign c2h_0_done = accept && pipe_out_last && sel[0];
  assign c2h_1_done = accept && pipe_out_last && sel[1];

endmodule

`default_nettype wire

/* frame_counters.sv */
// counters wrap silently at 2**count_width frames and clear only on reset
`default_nettype none
`timescale 1ns/10ps

module frame_counters import axis_width_pkg::*; (
  input  logic                   axis_aclk,
  input  logic                   axis_rst,
  input  logic                   h2c_done,
  input  logic                   c2h_0_done,
  input  logic                   c2h_1_done,
  output logic [count_width-1:0] h2c_frames,
  output logic [count_width-1:0] c2h_0_frames,
  output logic [count_width-1:0] c2h_1_frames
);

  logic [2:0]             done;
  logic [count_width-1:0] count [3];

  // index 0 is host-to-card, 1 and 2 the card-to-host queues
  assign done = {c2h_1_done, c2h_0_done, h2c_done};

  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      for (int i = 0; i < 3; i++) begin
        count[i] <= '0;
      end
    end
    else begin
      for (int i = 0; i < 3; i++) begin
        if (done[i]) begin
          count[i] <= count[i] + 1'b1;
        end
      end
    end
  end

  assign h2c_frames   = count[0];
  assign c2h_0_frames = count[1];
  assign c2h_1_frames = count[2];

endmodule

`default_nettype wire

/* dma_attach.sv */
// single clock domain; axis_rst must be synchronous to axis_aclk and pipe_in has no back-pressure
`default_nettype none
`timescale 1ns/10ps

module dma_attach import axis_width_pkg::*, port_map_pkg::*; (
  input  logic                   axis_aclk,
  input  logic                   axis_rst,
  // host-to-card queues
  input  logic                   h2c_0_valid,
  input  logic [tdata_width-1:0] h2c_0_data,
  input  logic [tkeep_width-1:0] h2c_0_keep,
  input  logic                   h2c_0_last,
  input  logic [size_width-1:0]  h2c_0_size,
  output logic                   h2c_0_ready,
  input  logic                   h2c_1_valid,
  input  logic [tdata_width-1:0] h2c_1_data,
  input  logic [tkeep_width-1:0] h2c_1_keep,
  input  logic                   h2c_1_last,
  input  logic [size_width-1:0]  h2c_1_size,
  output logic                   h2c_1_ready,
  // merged stream into the pipeline
  output logic                   pipe_in_valid,
  output logic [tdata_width-1:0] pipe_in_data,
  output logic [tkeep_width-1:0] pipe_in_keep,
  output logic                   pipe_in_last,
  output logic [tuser_width-1:0] pipe_in_user,
  // stream leaving the pipeline
  input  logic                   pipe_out_valid,
  input  logic [tdata_width-1:0] pipe_out_data,
  input  logic [tkeep_width-1:0] pipe_out_keep,
  input  logic                   pipe_out_last,
  input  logic [tuser_width-1:0] pipe_out_user,
  output logic                   pipe_out_ready,
  // card-to-host queues
  output logic                   c2h_0_valid,
  output logic [tdata_width-1:0] c2h_0_data,
  output logic [tkeep_width-1:0] c2h_0_keep,
  output logic                   c2h_0_last,
  output logic [15:0]            c2h_0_size,
  output logic [15:0]            c2h_0_src,
  output logic [15:0]            c2h_0_dst,
  input  logic                   c2h_0_ready,
  output logic                   c2h_1_valid,
  output logic [tdata_width-1:0] c2h_1_data,
  output logic [tkeep_width-1:0] c2h_1_keep,
  output logic                   c2h_1_last,
  output logic [15:0]            c2h_1_size,
  output logic [15:0]            c2h_1_src,
  output logic [15:0]            c2h_1_dst,
  input  logic                   c2h_1_ready,
  // finished-frame counts
  output logic [count_width-1:0] h2c_frames,
  output logic [count_width-1:0] c2h_0_frames,
  output logic [count_width-1:0] c2h_1_frames
);

  grant_t grant;
  logic   take;
  logic   h2c_done;
  logic   c2h_0_done;
  logic   c2h_1_done;

  // sub-block port names match the top level signal names
  h2c_arbiter u_h2c_arbiter (.*);

  h2c_merge u_h2c_merge (.*);

  c2h_dispatch u_c2h_dispatch (.*);

  frame_counters u_frame_counters (.*);

endmodule

`default_nettype wire

/* dma_attach_asserts.sv */
// bound to dma_attach; uses its internal grant signal, checks are off while axis_rst is high
`default_nettype none
`timescale 1ns/10ps

module dma_attach_asserts import port_map_pkg::*; (
  input logic   axis_aclk,
  input logic   axis_rst,
  input logic   h2c_0_valid,
  input logic   h2c_0_last,
  input logic   h2c_0_ready,
  input logic   h2c_1_valid,
  input logic   h2c_1_last,
  input logic   h2c_1_ready,
  input grant_t grant,
  input logic   pipe_in_valid,
  input logic   pipe_out_ready,
  input logic   c2h_0_ready,
  input logic   c2h_1_ready
);

  // only one host queue may be offered ready at a time
  assert property (@(posedge axis_aclk) disable iff (axis_rst) !(h2c_0_ready && h2c_1_ready))
    else $error("both host readies high");

  // a grant lasts until the last beat of its frame is taken
  assert property (@(posedge axis_aclk) disable iff (axis_rst)
    (grant == grant_q0 && !(h2c_0_valid && h2c_0_ready && h2c_0_last)) |=> grant == grant_q0)
    else $error("queue 0 lost its grant mid-frame");

  assert property (@(posedge axis_aclk) disable iff (axis_rst)
    (grant == grant_q1 && !(h2c_1_valid && h2c_1_ready && h2c_1_last)) |=> grant == grant_q1)
    else $error("queue 1 lost its grant mid-frame");

  assert property (@(posedge axis_aclk) disable iff (axis_rst)
    pipe_out_ready == (c2h_0_ready && c2h_1_ready))
    else $error("pipe_out_ready differs from the AND of the queue readies");

  assert property (@(posedge axis_aclk) axis_rst |=> !h2c_0_ready && !h2c_1_ready && !pipe_in_valid)
    else $error("outputs not cleared after reset");

endmodule

bind dma_attach dma_attach_asserts u_asserts (.*);

`default_nettype wire

/* tb_dma_attach.sv */
// single-seed run; expects the 512-bit data and 128-bit metadata layout of axis_width_pkg
`default_nettype none
`timescale 1ns/10ps

module tb_dma_attach import axis_width_pkg::*, port_map_pkg::*;;

  localparam int max_len     = 5;
  localparam int n_load      = 6;
  localparam int n_c2h       = 12;
  localparam int stim_cycles = (2 + 2 * n_load + 3 + 2 * n_c2h) * max_len + 60;

  logic axis_aclk = 1'b0;
  logic axis_rst;
  logic h2c_0_valid, h2c_0_last, h2c_0_ready, h2c_1_valid, h2c_1_last, h2c_1_ready;
  logic [tdata_width-1:0] h2c_0_data, h2c_1_data, pipe_in_data, pipe_out_data;
  logic [tdata_width-1:0] c2h_0_data, c2h_1_data;
  logic [tkeep_width-1:0] h2c_0_keep, h2c_1_keep, pipe_in_keep, pipe_out_keep;
  logic [tkeep_width-1:0] c2h_0_keep, c2h_1_keep;
  logic [size_width-1:0]  h2c_0_size, h2c_1_size;
  logic pipe_in_valid, pipe_in_last, pipe_out_valid, pipe_out_last, pipe_out_ready;
  logic [tuser_width-1:0] pipe_in_user, pipe_out_user;
  logic c2h_0_valid, c2h_0_last, c2h_0_ready, c2h_1_valid, c2h_1_last, c2h_1_ready;
  logic [15:0] c2h_0_size, c2h_0_src, c2h_0_dst, c2h_1_size, c2h_1_src, c2h_1_dst;
  logic [count_width-1:0] h2c_frames, c2h_0_frames, c2h_1_frames;

  integer seed = 32'hd56f;
  int h2c_sent = 0;
  int c2h0_sent = 0;
  int c2h1_sent = 0;
  bit alt_check = 1'b0;
  // expected beats: {user, last, keep, data} and {dst, src, size, last, keep, data}
  logic [tuser_width+tkeep_width+tdata_width:0] exp_in [$];
  logic [48+tkeep_width+tdata_width:0]          exp_c2h [2][$];

  dma_attach uut (.*);

  always #10 axis_aclk = ~axis_aclk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [tdata_width-1:0] got,
                             input logic [tdata_width-1:0] exp);
    assert (got === exp) else begin
      fail_run($sformatf("FAILED %s: got %0h expected %0h", name, got, exp));
    end
  endtask

  function automatic logic [tdata_width-1:0] rand_data();
    logic [tdata_width-1:0] d;
    for (int i = 0; i < tdata_width / 32; i++) begin
      d[i*32 +: 32] = $random(seed);
    end
    return d;
  endfunction

  // reference model: merged beat carries size and the one-hot source code, all else zero
  function automatic logic [tuser_width+tkeep_width+tdata_width:0] expect_h2c_beat(
      input int q, input logic [tdata_width-1:0] d, input logic [tkeep_width-1:0] k,
      input logic l, input logic [15:0] size);
    logic [tuser_width-1:0] user;
    user = '0;
    user[size_lsb +: size_width] = size;
    user[src_lsb +: port_width]  = (q == 0) ? qdma0_ifnum : qdma1_ifnum;
    return {user, l, k, d};
  endfunction

  // size comes from the first beat, src from the live beat, dst is the queue code
  function automatic logic [48+tkeep_width+tdata_width:0] expect_c2h_beat(
      input int q, input logic [tdata_width-1:0] d, input logic [tkeep_width-1:0] k,
      input logic l, input logic [tuser_width-1:0] first_user, input logic [tuser_width-1:0] user);
    logic [15:0] dst;
    dst = (q == 0) ? qdma0_dst_code : qdma1_dst_code;
    return {dst, 8'h00, user[src_lsb +: port_width], first_user[size_lsb +: size_width], l, k, d};
  endfunction

  task automatic send_h2c(input int q, input int len);
    logic [15:0]            size;
    logic [tdata_width-1:0] d;
    logic [tkeep_width-1:0] k;
    logic                   r;
    size = $random(seed);
    for (int b = 0; b < len; b++) begin
      d = rand_data();
      k = {$random(seed), $random(seed)};
      if (q == 0) begin
        {h2c_0_valid, h2c_0_data, h2c_0_keep, h2c_0_last, h2c_0_size} =
          {1'b1, d, k, b == len - 1, size};
      end
      else begin
        {h2c_1_valid, h2c_1_data, h2c_1_keep, h2c_1_last, h2c_1_size} =
          {1'b1, d, k, b == len - 1, size};
      end
      // ready only changes on the rising edge, so its value here decides the transfer
      do begin
        r = (q == 0) ? h2c_0_ready : h2c_1_ready;
        if (r) exp_in.push_back(expect_h2c_beat(q, d, k, b == len - 1, size));
        @(negedge axis_aclk);
      end while (!r);
    end
    if (q == 0) h2c_0_valid = 1'b0;
    else h2c_1_valid = 1'b0;
    h2c_sent++;
  endtask

  task automatic send_c2h(input logic [1:0] sel, input int len, input bit jitter);
    logic [tuser_width-1:0] first_user;
    logic [tuser_width-1:0] user;
    logic [7:0]             dst;
    logic                   acc;
    dst = ($random(seed) & 8'hf5) | {4'b0, sel[1], 1'b0, sel[0], 1'b0};
    for (int b = 0; b < len; b++) begin
      user = {$random(seed), $random(seed), $random(seed), $random(seed)};
      user[dst_lsb +: port_width] = dst;
      if (b == 0) first_user = user;
      pipe_out_valid = 1'b1;
      pipe_out_data  = rand_data();
      pipe_out_keep  = {$random(seed), $random(seed)};
      pipe_out_last  = (b == len - 1);
      pipe_out_user  = user;
      do begin
        if (jitter) begin
          c2h_0_ready = ($random(seed) & 3) != 0;
          c2h_1_ready = ($random(seed) & 3) != 0;
        end
        acc = c2h_0_ready && c2h_1_ready;
        for (int q = 0; q < 2; q++) begin
          if (acc && sel[q]) begin
            exp_c2h[q].push_back(expect_c2h_beat(q, pipe_out_data, pipe_out_keep,
                                                 pipe_out_last, first_user, user));
          end
        end
        @(negedge axis_aclk);
      end while (!acc);
    end
    pipe_out_valid = 1'b0;
    c2h_0_ready = 1'b1;
    c2h_1_ready = 1'b1;
    c2h0_sent += sel[0];
    c2h1_sent += sel[1];
  endtask

  // compare process samples mid-cycle, well away from both clock edges
  always @(negedge axis_aclk) begin : compare
    logic [tuser_width+tkeep_width+tdata_width:0] e;
    logic [48+tkeep_width+tdata_width:0]          c;
    static bit         in_frame = 1'b0;
    static logic [7:0] frame_src = '0;
    static logic [7:0] last_src = '0;
    #5;
    if (!alt_check) last_src = '0;
    if (pipe_in_valid && !axis_rst) begin
      assert (exp_in.size() > 0) else fail_run("pipe_in carried a beat that was never sent");
      e = exp_in.pop_front();
      check_value("pipe_in_data", pipe_in_data, e[tdata_width-1:0]);
      check_value("pipe_in_keep", pipe_in_keep, e[tdata_width +: tkeep_width]);
      check_value("pipe_in_last", pipe_in_last, e[tdata_width+tkeep_width]);
      check_value("pipe_in_user", pipe_in_user, e[tdata_width+tkeep_width+1 +: tuser_width]);
      if (!in_frame) begin
        frame_src = pipe_in_user[src_lsb +: port_width];
        assert (!alt_check || last_src == 0 || frame_src != last_src) else
          fail_run("host queues did not alternate under load");
        last_src = frame_src;
      end
      else begin
        assert (pipe_in_user[src_lsb +: port_width] == frame_src) else
          fail_run("merged frames interleaved on pipe_in");
      end
      in_frame = !pipe_in_last;
    end
    for (int q = 0; q < 2; q++) begin
      if ((q == 0) ? (c2h_0_valid && c2h_0_ready) : (c2h_1_valid && c2h_1_ready)) begin
        assert (exp_c2h[q].size() > 0) else
          fail_run($sformatf("unexpected beat on c2h queue %0d", q));
        c = exp_c2h[q].pop_front();
        if (q == 0) begin
          check_value("c2h_0_data", c2h_0_data, c[tdata_width-1:0]);
          check_value("c2h_0_keep", c2h_0_keep, c[tdata_width +: tkeep_width]);
          check_value("c2h_0_last", c2h_0_last, c[tdata_width+tkeep_width]);
          check_value("c2h_0_size/src/dst", {c2h_0_dst, c2h_0_src, c2h_0_size},
                      c[tdata_width+tkeep_width+1 +: 48]);
        end
        else begin
          check_value("c2h_1_data", c2h_1_data, c[tdata_width-1:0]);
          check_value("c2h_1_keep", c2h_1_keep, c[tdata_width +: tkeep_width]);
          check_value("c2h_1_last", c2h_1_last, c[tdata_width+tkeep_width]);
          check_value("c2h_1_size/src/dst", {c2h_1_dst, c2h_1_src, c2h_1_size},
                      c[tdata_width+tkeep_width+1 +: 48]);
        end
      end
    end
  end

  initial begin : watchdog
    #(stim_cycles * 4 * 20);
    fail_run("timeout: the run did not finish in the expected number of cycles");
  end

  initial begin : stimulus
    logic [1:0] sel;
    axis_rst = 1'b1;
    {h2c_0_valid, h2c_0_last, h2c_1_valid, h2c_1_last} = '0;
    {h2c_0_data, h2c_1_data, h2c_0_keep, h2c_1_keep, h2c_0_size, h2c_1_size} = '0;
    {pipe_out_valid, pipe_out_data, pipe_out_keep, pipe_out_last, pipe_out_user} = '0;
    c2h_0_ready = 1'b1;
    c2h_1_ready = 1'b1;
    repeat (5) @(negedge axis_aclk);
    axis_rst = 1'b0;
    check_value("h2c_0_ready", h2c_0_ready, 0);
    check_value("h2c_1_ready", h2c_1_ready, 0);
    check_value("pipe_in_valid", pipe_in_valid, 0);
    check_value("frame counters", {h2c_frames, c2h_0_frames, c2h_1_frames}, 0);
    // queue 1 goes last here, so queue 0 must win when both start together
    alt_check = 1'b1;
    send_h2c(0, 3);
    send_h2c(1, 4);
    fork
      for (int i = 0; i < n_load; i++) send_h2c(0, 1 + {$random(seed)} % max_len);
      for (int i = 0; i < n_load; i++) send_h2c(1, 1 + {$random(seed)} % max_len);
    join
    alt_check = 1'b0;
    send_c2h(2'b01, 3, 1'b0);
    send_c2h(2'b10, 2, 1'b0);
    send_c2h(2'b11, 4, 1'b0);
    for (int i = 0; i < n_c2h; i++) begin
      sel = 1 + {$random(seed)} % 3;
      send_c2h(sel, 1 + {$random(seed)} % max_len, 1'b1);
    end
    repeat (4) @(negedge axis_aclk);
    assert (exp_in.size() == 0 && exp_c2h[0].size() == 0 && exp_c2h[1].size() == 0) else
      fail_run("some expected beats never came out of the DUT");
    check_value("h2c_frames", h2c_frames, h2c_sent);
    check_value("c2h_0_frames", c2h_0_frames, c2h0_sent);
    check_value("c2h_1_frames", c2h_1_frames, c2h1_sent);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
axis_width_pkg.sv
port_map_pkg.sv
h2c_arbiter.sv
h2c_merge.sv
c2h_dispatch.sv
frame_counters.sv
dma_attach.sv
dma_attach_asserts.sv
tb_dma_attach.sv

/* Makefile */
# Verilator build and run of the dma_attach testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"

obj_dir/Vtb_dma_attach: list.f $(shell cat list.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_attach -f list.f

test: obj_dir/Vtb_dma_attach
	-./obj_dir/Vtb_dma_attach > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "test failed"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
